/* common/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address and cpu word
`define ADDR_W 32
`define WORD_W 32

// line geometry
`define LINE_WORDS 4
`define L1_LINES 16

// backing store
`define MEM_LINES 256
`define MEM_LATENCY 4 // accept to ready, in cycles

// statistics
`define CNT_W 16

`endif

/* common/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`LINE_WORDS*`WORD_W-1:0] line_t;
	typedef logic [`ADDR_W-$clog2(`LINE_WORDS*`WORD_W/8)-1:0] line_addr_t;
	typedef logic [`CNT_W-1:0] count_t;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

	typedef enum logic [2:0] {
		C_IDLE,
		C_LOOKUP,
		C_EVICT,
		C_FILL,
		C_RESPOND
	} cache_state_e;

	typedef enum logic [1:0] {
		G_NONE,
		G_INST,
		G_DATA
	} grant_e;

	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		word_t wdata;
		logic [`WORD_W/8-1:0] strobe;
		logic rd; // pulse
		logic wr; // pulse
	} cpu_req_t;

	typedef struct packed {
		word_t rdata;
		logic done; // one cycle
	} cpu_rsp_t;

	typedef struct packed {
		line_addr_t line_addr;
		line_t wdata;
		mem_op_e op;
		logic valid; // held until ready
	} mem_req_t;

	typedef struct packed {
		line_t rdata;
		logic ready;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* l1_cache/l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module l1_cache #(
	parameter bit WRITABLE = 1'b1
) (
	input wire clk_cpu,
	input wire rst,
	input wire cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::cpu_rsp_t cpu_rsp,
	output cache_pkg::mem_req_t mem_req,
	input wire cache_pkg::mem_rsp_t mem_rsp,
	output logic miss,
	output logic evict
);

	import cache_pkg::*;

	localparam int OFF_W = $clog2(`LINE_WORDS * `WORD_W / 8);
	localparam int WSEL_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(`L1_LINES);
	localparam int TAG_W = `ADDR_W - OFF_W - IDX_W;
	localparam int BYTES = `WORD_W / 8;

	cache_state_e state;
	cpu_req_t req_q;
	word_t rdata_q;

	line_t data_arr [`L1_LINES];
	logic [TAG_W-1:0] tag_arr [`L1_LINES];
	logic [`L1_LINES-1:0] valid_arr;
	logic [`L1_LINES-1:0] dirty_arr;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [WSEL_W-1:0] wsel;
	logic hit;
	logic accept;
	line_t cur_line;
	word_t cur_word;
	word_t merged;

	assign idx = req_q.addr[OFF_W +: IDX_W];
	assign tag = req_q.addr[`ADDR_W-1 -: TAG_W];
	assign wsel = req_q.addr[OFF_W-1 -: WSEL_W];
	assign cur_line = data_arr[idx];
	assign cur_word = cur_line[wsel*`WORD_W +: `WORD_W];
	assign hit = valid_arr[idx] && (tag_arr[idx] == tag);
	assign accept = cpu_req.rd || (WRITABLE && cpu_req.wr); // fetch side drops writes

	// byte merge for stores
	always_comb begin
		for (int b = 0; b < BYTES; b++) begin
			merged[b*8 +: 8] = req_q.strobe[b] ? req_q.wdata[b*8 +: 8] : cur_word[b*8 +: 8];
		end
	end

	assign miss = (state == C_LOOKUP) && !hit;
	assign evict = miss && dirty_arr[idx];

	always_comb begin
		cpu_rsp.rdata = rdata_q;
		cpu_rsp.done = (state == C_RESPOND);
	end

	always_comb begin
		mem_req.valid = (state == C_EVICT) || (state == C_FILL);
		mem_req.op = (state == C_EVICT) ? MEM_WRITE : MEM_READ;
		mem_req.line_addr = (state == C_EVICT) ? {tag_arr[idx], idx} : req_q.addr[`ADDR_W-1:OFF_W];
		mem_req.wdata = cur_line; // victim line on write-back
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state <= C_IDLE;
			valid_arr <= '0;
			dirty_arr <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (accept)
						state <= C_LOOKUP;
				end
				C_LOOKUP: begin
					if (hit) begin
						state <= C_RESPOND;
						if (req_q.wr)
							dirty_arr[idx] <= 1'b1;
					end else if (dirty_arr[idx]) begin
						state <= C_EVICT;
					end else begin
						state <= C_FILL;
					end
				end
				C_EVICT: begin
					if (mem_rsp.ready) begin
						dirty_arr[idx] <= 1'b0;
						state <= C_FILL;
					end
				end
				C_FILL: begin
					if (mem_rsp.ready) begin
						valid_arr[idx] <= 1'b1;
						dirty_arr[idx] <= 1'b0;
						state <= C_LOOKUP; // replay, now a hit
					end
				end
				C_RESPOND: state <= C_IDLE;
				default: state <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (state == C_IDLE && accept) begin
			req_q <= cpu_req;
			req_q.wr <= cpu_req.wr && WRITABLE;
		end
		if (state == C_LOOKUP && hit) begin
			rdata_q <= req_q.wr ? merged : cur_word;
			if (req_q.wr)
				data_arr[idx][wsel*`WORD_W +: `WORD_W] <= merged;
		end
		if (state == C_FILL && mem_rsp.ready) begin
			data_arr[idx] <= mem_rsp.rdata;
			tag_arr[idx] <= tag;
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input wire clk_cpu,
	input wire rst,
	input wire cache_pkg::mem_req_t inst_mem_req,
	input wire cache_pkg::mem_req_t data_mem_req,
	output cache_pkg::mem_rsp_t inst_mem_rsp,
	output cache_pkg::mem_rsp_t data_mem_rsp,
	output cache_pkg::mem_req_t mem_req,
	input wire cache_pkg::mem_rsp_t mem_rsp
);

	import cache_pkg::*;

	grant_e owner;
	logic last_data; // data side won last
	logic pick_data;

	assign pick_data = data_mem_req.valid && (!inst_mem_req.valid || !last_data);

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			owner <= G_NONE;
			last_data <= 1'b0;
		end else begin
			case (owner)
				G_NONE: begin
					if (inst_mem_req.valid || data_mem_req.valid) begin
						owner <= pick_data ? G_DATA : G_INST;
						last_data <= pick_data;
					end
				end
				default: begin
					if (mem_rsp.ready)
						owner <= G_NONE; // release after the transfer
				end
			endcase
		end
	end

	always_comb begin
		case (owner)
			G_INST: mem_req = inst_mem_req;
			G_DATA: mem_req = data_mem_req;
			default: mem_req = '0;
		endcase
	end

	// only the owner sees the response
	always_comb begin
		inst_mem_rsp.rdata = (owner == G_INST) ? mem_rsp.rdata : '0;
		inst_mem_rsp.ready = (owner == G_INST) && mem_rsp.ready;
		data_mem_rsp.rdata = (owner == G_DATA) ? mem_rsp.rdata : '0;
		data_mem_rsp.ready = (owner == G_DATA) && mem_rsp.ready;
	end

endmodule

`default_nettype wire

/* hdl/line_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module line_mem (
	input wire clk_cpu,
	input wire rst,
	input wire cache_pkg::mem_req_t mem_req,
	output cache_pkg::mem_rsp_t mem_rsp
);

	import cache_pkg::*;

	localparam int MIDX_W = $clog2(`MEM_LINES);
	localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

	line_t mem [`MEM_LINES];
	logic [CNT_BITS-1:0] cnt;
	logic [MIDX_W-1:0] addr_q;
	line_t wdata_q;
	mem_op_e op_q;
	logic accept;
	logic ready;

	initial begin
		for (int i = 0; i < `MEM_LINES; i++)
			mem[i] = '0;
	end

	assign accept = mem_req.valid && (cnt == '0);
	assign ready = (cnt == CNT_BITS'(1));

	always_ff @(posedge clk_cpu) begin
		if (rst)
			cnt <= '0;
		else if (accept)
			cnt <= CNT_BITS'(`MEM_LATENCY);
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	always_ff @(posedge clk_cpu) begin
		if (accept) begin
			addr_q <= mem_req.line_addr[MIDX_W-1:0]; // wraps modulo depth
			wdata_q <= mem_req.wdata;
			op_q <= mem_req.op;
		end
		if (ready && op_q == MEM_WRITE)
			mem[addr_q] <= wdata_q;
	end

	always_comb begin
		mem_rsp.rdata = mem[addr_q];
		mem_rsp.ready = ready;
	end

endmodule

`default_nettype wire

/* hdl/miss_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module miss_counter (
	input wire clk_cpu,
	input wire rst,
	input wire inst_miss,
	input wire data_miss,
	input wire inst_evict,
	input wire data_evict,
	output cache_pkg::count_t inst_misses,
	output cache_pkg::count_t data_misses,
	output cache_pkg::count_t evictions
);

	import cache_pkg::*;

	// sticks at all ones
	function automatic count_t sat_add(input count_t val, input logic [1:0] inc);
		logic [`CNT_W:0] sum;
		sum = {1'b0, val} + inc;
		return sum[`CNT_W] ? '1 : sum[`CNT_W-1:0];
	endfunction

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			inst_misses <= '0;
			data_misses <= '0;
			evictions <= '0;
		end else begin
			inst_misses <= sat_add(inst_misses, {1'b0, inst_miss});
			data_misses <= sat_add(data_misses, {1'b0, data_miss});
			evictions <= sat_add(evictions, 2'(inst_evict) + 2'(data_evict));
		end
	end

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
	input wire clk_cpu,
	input wire rst,
	input wire cache_pkg::cpu_req_t inst_req,
	input wire cache_pkg::cpu_req_t data_req,
	output cache_pkg::cpu_rsp_t inst_rsp,
	output cache_pkg::cpu_rsp_t data_rsp,
	output cache_pkg::count_t inst_misses,
	output cache_pkg::count_t data_misses,
	output cache_pkg::count_t evictions
);

	cache_pkg::mem_req_t inst_mem_req;
	cache_pkg::mem_req_t data_mem_req;
	cache_pkg::mem_req_t mem_req;
	cache_pkg::mem_rsp_t inst_mem_rsp;
	cache_pkg::mem_rsp_t data_mem_rsp;
	cache_pkg::mem_rsp_t mem_rsp;
	logic inst_miss;
	logic data_miss;
	logic inst_evict;
	logic data_evict;

	l1_cache #(
		.WRITABLE (1'b0) // fetch side
	) u_inst_cache (
		.clk_cpu (clk_cpu),
		.rst (rst),
		.cpu_req (inst_req),
		.cpu_rsp (inst_rsp),
		.mem_req (inst_mem_req),
		.mem_rsp (inst_mem_rsp),
		.miss (inst_miss),
		.evict (inst_evict)
	);

	l1_cache #(
		.WRITABLE (1'b1)
	) u_data_cache (
		.clk_cpu (clk_cpu),
		.rst (rst),
		.cpu_req (data_req),
		.cpu_rsp (data_rsp),
		.mem_req (data_mem_req),
		.mem_rsp (data_mem_rsp),
		.miss (data_miss),
		.evict (data_evict)
	);

	mem_arbiter u_mem_arbiter (
		.clk_cpu (clk_cpu),
		.rst (rst),
		.inst_mem_req (inst_mem_req),
		.data_mem_req (data_mem_req),
		.inst_mem_rsp (inst_mem_rsp),
		.data_mem_rsp (data_mem_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	line_mem u_line_mem (
		.clk_cpu (clk_cpu),
		.rst (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	miss_counter u_miss_counter (
		.clk_cpu (clk_cpu),
		.rst (rst),
		.inst_miss (inst_miss),
		.data_miss (data_miss),
		.inst_evict (inst_evict),
		.data_evict (data_evict),
		.inst_misses (inst_misses),
		.data_misses (data_misses),
		.evictions (evictions)
	);

endmodule

`default_nettype wire

/* bench/tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

	import cache_pkg::*;

	localparam int TIMEOUT = 500;

	logic clk_cpu;
	logic rst;
	cpu_req_t inst_req;
	cpu_req_t data_req;
	cpu_rsp_t inst_rsp;
	cpu_rsp_t data_rsp;
	count_t inst_misses;
	count_t data_misses;
	count_t evictions;

	// reference model with the fetch cache at index 0
	word_t back_mem [1024];
	word_t m_line [2][16][4];
	logic [23:0] m_tag [2][16];
	bit m_valid [2][16];
	bit m_dirty [2][16];
	int exp_imiss;
	int exp_dmiss;
	int exp_evict;
	int seed;

	int fd;
	int n;
	string line;
	string name;
	byte port;
	byte op;
	logic [31:0] addr;
	word_t wdata;
	logic [3:0] strb;
	word_t exp_word;
	word_t mval;
	word_t got;
	int lat;
	int pairs;
	count_t e_i;
	count_t e_d;
	count_t e_e;

	cache_top DUT (
		.clk_cpu (clk_cpu),
		.rst (rst),
		.inst_req (inst_req),
		.data_req (data_req),
		.inst_rsp (inst_rsp),
		.data_rsp (data_rsp),
		.inst_misses (inst_misses),
		.data_misses (data_misses),
		.evictions (evictions)
	);

	always #2 clk_cpu = ~clk_cpu;

	task automatic check_word(input string tname, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %h actual %h", tname, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string tname, input count_t exp, input count_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %0d actual %0d", tname, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic no_done();
		$display("no done from the cache");
		$display("Simulation failed");
		$fatal(1);
	endtask

	// write-back, allocate-on-write, direct-mapped over 16 lines of 4 words
	task automatic model_access(input int p, input logic [31:0] a, input bit wr,
			input word_t wd, input logic [3:0] sb, output word_t rd);
		logic [3:0] idx;
		logic [23:0] tg;
		logic [1:0] w;
		idx = a[7:4];
		tg = a[31:8];
		w = a[3:2];
		if (!(m_valid[p][idx] && m_tag[p][idx] == tg)) begin
			if (p == 0)
				exp_imiss++;
			else
				exp_dmiss++;
			if (m_dirty[p][idx]) begin
				exp_evict++;
				for (int j = 0; j < 4; j++)
					back_mem[{m_tag[p][idx][3:0], idx, 2'(j)}] = m_line[p][idx][j];
			end
			for (int j = 0; j < 4; j++)
				m_line[p][idx][j] = back_mem[{tg[3:0], idx, 2'(j)}];
			m_valid[p][idx] = 1'b1;
			m_dirty[p][idx] = 1'b0;
			m_tag[p][idx] = tg;
		end
		if (wr) begin
			for (int b = 0; b < 4; b++)
				if (sb[b])
					m_line[p][idx][w][b*8 +: 8] = wd[b*8 +: 8];
			m_dirty[p][idx] = 1'b1;
		end
		rd = m_line[p][idx][w];
	endtask

	// lat counts edges from the sampling edge to the one that shows done
	task automatic do_op(input bit is_inst, input bit wr, input logic [31:0] a,
			input word_t wd, input logic [3:0] sb, output word_t rd, output int cyc);
		cpu_req_t req;
		cpu_rsp_t rsp;
		req = '0;
		req.addr = a;
		req.wdata = wd;
		req.strobe = sb;
		req.rd = !wr;
		req.wr = wr;
		@(posedge clk_cpu);
		#1;
		if (is_inst)
			inst_req = req;
		else
			data_req = req;
		@(posedge clk_cpu);
		#1;
		inst_req.rd = 1'b0;
		inst_req.wr = 1'b0;
		data_req.rd = 1'b0;
		data_req.wr = 1'b0;
		cyc = 1;
		rsp = is_inst ? inst_rsp : data_rsp;
		while (!rsp.done) begin
			if (cyc >= TIMEOUT)
				no_done();
			@(posedge clk_cpu);
			#1;
			cyc++;
			rsp = is_inst ? inst_rsp : data_rsp;
		end
		rd = rsp.rdata;
	endtask

	// fetch read and data write issued on the same edge
	task automatic do_pair(input logic [31:0] ia, input logic [31:0] da, input word_t wd,
			output word_t gi, output word_t gd);
		bit seen_i;
		bit seen_d;
		int cyc;
		seen_i = 0;
		seen_d = 0;
		cyc = 0;
		@(posedge clk_cpu);
		#1;
		inst_req = '0;
		inst_req.addr = ia;
		inst_req.rd = 1'b1;
		data_req = '0;
		data_req.addr = da;
		data_req.wdata = wd;
		data_req.strobe = 4'hf;
		data_req.wr = 1'b1;
		@(posedge clk_cpu);
		#1;
		inst_req.rd = 1'b0;
		data_req.wr = 1'b0;
		while (!(seen_i && seen_d)) begin
			if (cyc >= TIMEOUT)
				no_done();
			@(posedge clk_cpu);
			#1;
			cyc++;
			if (inst_rsp.done) begin
				gi = inst_rsp.rdata;
				seen_i = 1;
			end
			if (data_rsp.done) begin
				gd = data_rsp.rdata;
				seen_d = 1;
			end
		end
	endtask

	// later fetches read lines that earlier pairs wrote back
	task automatic run_burst(input int cnt);
		word_t wv [16];
		word_t ei;
		word_t ed;
		word_t gi;
		word_t gd;
		int cyc;
		for (int k = 0; k < cnt; k++) begin
			wv[k] = $random(seed);
			model_access(0, 32'h608 + k * 32'h100, 0, '0, 4'h0, ei);
			model_access(1, 32'h808 + k * 32'h100, 1, wv[k], 4'hf, ed);
			do_pair(32'h608 + k * 32'h100, 32'h808 + k * 32'h100, wv[k], gi, gd);
			check_word($sformatf("burst fetch %0d", k), ei, gi);
			check_word($sformatf("burst store %0d", k), ed, gd);
		end
		for (int k = 0; k < cnt; k++) begin
			model_access(1, 32'h808 + k * 32'h100, 0, '0, 4'h0, ed);
			check_word($sformatf("burst model %0d", k), wv[k], ed);
			do_op(0, 0, 32'h808 + k * 32'h100, '0, 4'h0, gd, cyc);
			check_word($sformatf("burst readback %0d", k), ed, gd);
		end
	endtask

	initial begin
		clk_cpu = 1'b0;
		rst = 1'b1;
		inst_req = '0;
		data_req = '0;
		seed = 32'h81cb9c44;
		exp_imiss = 0;
		exp_dmiss = 0;
		exp_evict = 0;
		for (int i = 0; i < 1024; i++)
			back_mem[i] = '0;
		for (int p = 0; p < 2; p++)
			for (int i = 0; i < 16; i++) begin
				m_valid[p][i] = 0;
				m_dirty[p][i] = 0;
				m_tag[p][i] = '0;
			end
		repeat (10) @(posedge clk_cpu);
		#1;
		rst = 1'b0;

		fd = $fopen("bench/cache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("Simulation failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 3 || line[0] == 8'h23)
				continue;
			n = $sscanf(line, "%c", port);
			if (port == "b") begin
				n = $sscanf(line, "%c %d", port, pairs);
				run_burst(pairs);
			end else if (port == "t") begin
				n = $sscanf(line, "%c %h %h %h", port, e_i, e_d, e_e);
				check_count("model inst misses", e_i, count_t'(exp_imiss));
				check_count("model data misses", e_d, count_t'(exp_dmiss));
				check_count("model evictions", e_e, count_t'(exp_evict));
				check_count("inst misses", e_i, inst_misses);
				check_count("data misses", e_d, data_misses);
				check_count("evictions", e_e, evictions);
			end else begin
				n = $sscanf(line, "%c %c %h %h %h %h", port, op, addr, wdata, strb, exp_word);
				name = $sformatf("%c%c@%h", port, op, addr);
				model_access(port == "i" ? 0 : 1, addr, op == "w", wdata, strb, mval);
				check_word({name, " model"}, exp_word, mval);
				do_op(port == "i", op == "w", addr, wdata, strb, got, lat);
				check_word(name, exp_word, got);
				if (op == "h")
					check_count({name, " hit latency"}, count_t'(2), count_t'(lat));
			end
		end
		$fclose(fd);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* cache_hier.f */
+incdir+common
common/cache_pkg.sv
l1_cache/l1_cache.sv
hdl/mem_arbiter.sv
hdl/line_mem.sv
hdl/miss_counter.sv
hdl/cache_top.sv
bench/tb_cache_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache hierarchy testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_cache_top \
	-f cache_hier.f \
	--Mdir obj_dir -o sim_cache
if [ $? -ne 0 ]; then
	echo "build step failed"
	exit 1
fi

./obj_dir/sim_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/cache_stimulus.txt */
# port op addr wdata strobe expected (port i or d, op r read, w write, h read timed as a hit)
# b <pairs> runs a contention burst, t <inst_misses> <data_misses> <evictions> closes the run
i r 00000040 00000000 0 00000000
d r 00000080 00000000 0 00000000
d w 00000100 11223344 f 11223344
d w 00000100 aabbccdd 5 11bb33dd
d h 00000100 00000000 0 11bb33dd
d w 00000104 55667788 c 55660000
d r 00000200 00000000 0 00000000
d r 00000100 00000000 0 11bb33dd
d r 00000104 00000000 0 55660000
d h 00000104 00000000 0 55660000
i r 00000100 00000000 0 11bb33dd
i h 00000100 00000000 0 11bb33dd
i h 00000040 00000000 0 00000000
b 4
t 0006 000c 0005
